/* hw/csr_index_params.svh */
`ifndef CSR_INDEX_PARAMS_SVH
`define CSR_INDEX_PARAMS_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
`define CSR_ADDR_W      32
`define CSR_DATA_W      32
`define CSR_COUNT_W     16

// Stride between two index array entries
`define CSR_WORD_BYTES  4

// --------------------------------------------------
// Buffering and routing
// --------------------------------------------------
`define CSR_FIFO_DEPTH  16
`define CSR_PROG_THRESH 12
`define CSR_NUM_ROUTES  2

`endif

/* hw/csr_index_pkg.sv */
`include "csr_index_params.svh"

package csr_index_pkg;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    typedef enum logic [1:0] {
        CMD_CONFIG      = 2'd0,
        CMD_READ        = 2'd1,
        CMD_READ_RESP   = 2'd2,
        CMD_ENGINE_DATA = 2'd3
    } csr_opcode_e;

    // Selected by the low address bits of a config word
    typedef enum logic [1:0] {
        FIELD_BASE  = 2'd0,
        FIELD_START = 2'd1,
        FIELD_COUNT = 2'd2
    } csr_field_e;

    typedef enum logic [2:0] {
        GEN_RESET       = 3'd0,
        GEN_IDLE        = 3'd1,
        GEN_WAIT_CONFIG = 3'd2,
        GEN_BUSY        = 3'd3,
        GEN_DRAIN       = 3'd4,
        GEN_DONE        = 3'd5
    } gen_state_e;

    // --------------------------------------------------
    // Packets and control bundles
    // --------------------------------------------------
    typedef struct packed {
        logic                   id_module;
        csr_opcode_e            opcode;
        logic [`CSR_ADDR_W-1:0] address;
        logic [`CSR_DATA_W-1:0] data;
    } mem_payload_t;

    typedef struct packed {
        logic         valid;
        mem_payload_t payload;
    } mem_packet_t;

    typedef struct packed {
        logic                    valid;
        logic [`CSR_ADDR_W-1:0]  array_base;
        logic [`CSR_ADDR_W-1:0]  index_start;
        logic [`CSR_COUNT_W-1:0] index_count;
    } csr_config_t;

    typedef struct packed {
        logic                   valid;
        logic [`CSR_DATA_W-1:0] kernel_tag;
    } descriptor_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic prog_full;
    } fifo_status_t;

endpackage

/* hw/packet_fifo.sv */
`timescale 1ns/1ps
`include "csr_index_params.svh"

module packet_fifo #(
    parameter int DEPTH       = `CSR_FIFO_DEPTH,
    parameter int PROG_THRESH = `CSR_PROG_THRESH
) (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  logic                        push_i,
    input  csr_index_pkg::mem_payload_t din_i,
    input  logic                        pop_i,
    output csr_index_pkg::mem_payload_t dout_o,
    output logic                        dout_valid_o,
    output csr_index_pkg::fifo_status_t status_o
);

    localparam int PTR_W = $clog2(DEPTH);

    csr_index_pkg::mem_payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    // Overflow and underflow are blocked here as well
    assign do_pop  = pop_i && !status_o.empty;
    assign do_push = push_i && !status_o.full;

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            dout_valid_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            dout_valid_o <= do_pop;
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din_i;
        end
        if (do_pop) begin
            dout_o <= mem[rd_ptr];
        end
    end

    assign status_o.empty     = (count == '0);
    assign status_o.full      = (count >= DEPTH);
    assign status_o.prog_full = (count >= PROG_THRESH);

endmodule

/* hw/response_router.sv */
`timescale 1ns/1ps
`include "csr_index_params.svh"

module response_router (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  csr_index_pkg::mem_payload_t fifo_dout_i,
    input  logic                        fifo_dout_valid_i,
    input  csr_index_pkg::fifo_status_t fifo_status_i,
    input  logic                        gen_stall_i,
    output logic                        fifo_pop_o,
    output csr_index_pkg::mem_packet_t  route_o [`CSR_NUM_ROUTES]
);

    csr_index_pkg::mem_payload_t peek_q;
    logic                        peek_valid_q;
    logic                        drain;

    // Only generator traffic waits on the stall
    assign drain = peek_valid_q && !(peek_q.id_module && gen_stall_i);

    // One packet in flight at most, either in the FIFO read stage or in peek
    assign fifo_pop_o = !fifo_status_i.empty && !fifo_dout_valid_i
                        && (!peek_valid_q || drain);

    // --------------------------------------------------
    // Peek-ahead register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            peek_valid_q <= 1'b0;
        end else if (fifo_dout_valid_i) begin
            peek_valid_q <= 1'b1;
        end else if (drain) begin
            peek_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (fifo_dout_valid_i) begin
            peek_q <= fifo_dout_i;
        end
    end

    // --------------------------------------------------
    // Per destination output registers
    // --------------------------------------------------
    for (genvar d = 0; d < `CSR_NUM_ROUTES; d++) begin : g_route
        always_ff @(posedge ap_clk) begin
            route_o[d].payload <= peek_q;
            if (areset_csr_engine) begin
                route_o[d].valid <= 1'b0;
            end else begin
                route_o[d].valid <= drain && (peek_q.id_module == d);
            end
        end
    end

endmodule

/* hw/csr_index_configure.sv */
`timescale 1ns/1ps
`include "csr_index_params.svh"

module csr_index_configure (
    input  logic                       ap_clk,
    input  logic                       areset_csr_engine,
    input  csr_index_pkg::mem_packet_t cfg_pkt_i,
    input  logic                       consume_i,
    output csr_index_pkg::csr_config_t cfg_o
);

    csr_index_pkg::csr_field_e field;

    logic                    cfg_write;
    logic [2:0]              field_hit;
    logic [2:0]              field_mask_q;
    logic [`CSR_ADDR_W-1:0]  base_q;
    logic [`CSR_ADDR_W-1:0]  start_q;
    logic [`CSR_COUNT_W-1:0] count_q;

    assign cfg_write = cfg_pkt_i.valid
                       && (cfg_pkt_i.payload.opcode == csr_index_pkg::CMD_CONFIG);
    assign field     = csr_index_pkg::csr_field_e'(cfg_pkt_i.payload.address[1:0]);

    // Field decode
    always_comb begin
        field_hit = 3'b000;
        if (cfg_write) begin
            case (field)
                csr_index_pkg::FIELD_BASE:  field_hit = 3'b001;
                csr_index_pkg::FIELD_START: field_hit = 3'b010;
                csr_index_pkg::FIELD_COUNT: field_hit = 3'b100;
                default:                    field_hit = 3'b000;
            endcase
        end
    end

    // --------------------------------------------------
    // Written-field mask
    // --------------------------------------------------
    // A write in the consume cycle already counts for the next run
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            field_mask_q <= 3'b000;
        end else begin
            field_mask_q <= (consume_i ? 3'b000 : field_mask_q) | field_hit;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (field_hit[0]) begin
            base_q <= cfg_pkt_i.payload.data;
        end
        if (field_hit[1]) begin
            start_q <= cfg_pkt_i.payload.data;
        end
        if (field_hit[2]) begin
            count_q <= cfg_pkt_i.payload.data[`CSR_COUNT_W-1:0];
        end
    end

    assign cfg_o.valid       = &field_mask_q;
    assign cfg_o.array_base  = base_q;
    assign cfg_o.index_start = start_q;
    assign cfg_o.index_count = count_q;

endmodule

/* hw/csr_index_generator.sv */
`timescale 1ns/1ps
`include "csr_index_params.svh"

module csr_index_generator (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  csr_index_pkg::descriptor_t  descriptor_i,
    input  csr_index_pkg::csr_config_t  cfg_i,
    input  csr_index_pkg::mem_packet_t  resp_i,
    input  csr_index_pkg::fifo_status_t req_fifo_status_i,
    input  csr_index_pkg::fifo_status_t engine_fifo_status_i,
    output csr_index_pkg::mem_payload_t req_o,
    output logic                        req_push_o,
    output csr_index_pkg::mem_payload_t engine_o,
    output logic                        engine_push_o,
    output logic                        gen_stall_o,
    output logic                        cfg_consume_o,
    output logic                        done_o
);

    csr_index_pkg::gen_state_e  state_q;

    logic [`CSR_ADDR_W-1:0]  base_q;
    logic [`CSR_ADDR_W-1:0]  index_q;
    logic [`CSR_COUNT_W-1:0] count_q;
    logic [`CSR_COUNT_W-1:0] issued_q;
    logic [`CSR_COUNT_W-1:0] received_q;
    logic                    cfg_take;
    logic                    issue;
    logic                    resp_take;

    assign cfg_take  = (state_q == csr_index_pkg::GEN_WAIT_CONFIG) && cfg_i.valid;
    assign issue     = (state_q == csr_index_pkg::GEN_BUSY) && !req_fifo_status_i.prog_full;
    assign resp_take = resp_i.valid
                       && (resp_i.payload.opcode == csr_index_pkg::CMD_READ_RESP);

    // Router holds generator responses while the engine FIFO is nearly full
    assign gen_stall_o = engine_fifo_status_i.prog_full;

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state_q       <= csr_index_pkg::GEN_RESET;
            cfg_consume_o <= 1'b0;
            done_o        <= 1'b1;
        end else begin
            cfg_consume_o <= 1'b0;
            case (state_q)
                csr_index_pkg::GEN_RESET: begin
                    state_q <= csr_index_pkg::GEN_IDLE;
                end
                csr_index_pkg::GEN_IDLE: begin
                    if (descriptor_i.valid) begin
                        done_o  <= 1'b0;
                        state_q <= csr_index_pkg::GEN_WAIT_CONFIG;
                    end
                end
                csr_index_pkg::GEN_WAIT_CONFIG: begin
                    if (cfg_take) begin
                        cfg_consume_o <= 1'b1;
                        // Empty range finishes at once
                        if (cfg_i.index_count == '0) begin
                            state_q <= csr_index_pkg::GEN_DONE;
                        end else begin
                            state_q <= csr_index_pkg::GEN_BUSY;
                        end
                    end
                end
                csr_index_pkg::GEN_BUSY: begin
                    if (issue && (issued_q == count_q - 1'b1)) begin
                        state_q <= csr_index_pkg::GEN_DRAIN;
                    end
                end
                csr_index_pkg::GEN_DRAIN: begin
                    if (received_q == count_q) begin
                        state_q <= csr_index_pkg::GEN_DONE;
                    end
                end
                csr_index_pkg::GEN_DONE: begin
                    done_o  <= 1'b1;
                    state_q <= csr_index_pkg::GEN_IDLE;
                end
                default: state_q <= csr_index_pkg::GEN_RESET;
            endcase
        end
    end

    // Range and progress counters, loaded when the config is taken
    always_ff @(posedge ap_clk) begin
        if (cfg_take) begin
            base_q     <= cfg_i.array_base;
            index_q    <= cfg_i.index_start;
            count_q    <= cfg_i.index_count;
            issued_q   <= '0;
            received_q <= '0;
        end else begin
            if (issue) begin
                issued_q <= issued_q + 1'b1;
                index_q  <= index_q + 1'b1;
            end
            if (resp_take) begin
                received_q <= received_q + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Request and forward registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            req_push_o    <= 1'b0;
            engine_push_o <= 1'b0;
        end else begin
            req_push_o    <= issue;
            engine_push_o <= resp_take;
        end
    end

    always_ff @(posedge ap_clk) begin
        req_o.id_module    <= 1'b1;
        req_o.opcode       <= csr_index_pkg::CMD_READ;
        req_o.address      <= base_q + index_q * `CSR_WORD_BYTES;
        req_o.data         <= '0;
        engine_o.id_module <= 1'b1;
        engine_o.opcode    <= csr_index_pkg::CMD_ENGINE_DATA;
        engine_o.address   <= resp_i.payload.address;
        engine_o.data      <= resp_i.payload.data;
    end

endmodule

/* hw/engine_csr_index.sv */
`timescale 1ns/1ps
`include "csr_index_params.svh"

module engine_csr_index (
    input  logic                       ap_clk,
    input  logic                       areset_csr_engine,
    input  csr_index_pkg::descriptor_t descriptor_i,
    input  csr_index_pkg::mem_packet_t mem_resp_i,
    input  logic                       mem_req_pop_i,
    input  logic                       engine_out_pop_i,
    output logic                       mem_resp_prog_full_o,
    output csr_index_pkg::mem_packet_t mem_req_o,
    output csr_index_pkg::mem_packet_t engine_out_o,
    output logic                       done_o
);

    csr_index_pkg::descriptor_t   descriptor_q;
    csr_index_pkg::mem_packet_t   mem_resp_q;
    logic                         mem_req_pop_q;
    logic                         engine_out_pop_q;

    csr_index_pkg::mem_payload_t  resp_dout;
    csr_index_pkg::mem_payload_t  req_din;
    csr_index_pkg::mem_payload_t  req_dout;
    csr_index_pkg::mem_payload_t  eng_din;
    csr_index_pkg::mem_payload_t  eng_dout;
    csr_index_pkg::fifo_status_t  resp_status;
    csr_index_pkg::fifo_status_t  req_status;
    csr_index_pkg::fifo_status_t  eng_status;
    logic                         resp_pop;
    logic                         resp_dout_valid;
    logic                         req_push;
    logic                         req_pop;
    logic                         req_dout_valid;
    logic                         eng_push;
    logic                         eng_pop;
    logic                         eng_dout_valid;

    csr_index_pkg::mem_packet_t   route [`CSR_NUM_ROUTES];
    csr_index_pkg::csr_config_t   cfg;
    logic                         cfg_consume;
    logic                         gen_stall;
    logic                         gen_done;

    // --------------------------------------------------
    // Input registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        descriptor_q.kernel_tag <= descriptor_i.kernel_tag;
        mem_resp_q.payload      <= mem_resp_i.payload;
        if (areset_csr_engine) begin
            descriptor_q.valid <= 1'b0;
            mem_resp_q.valid   <= 1'b0;
            mem_req_pop_q      <= 1'b0;
            engine_out_pop_q   <= 1'b0;
        end else begin
            descriptor_q.valid <= descriptor_i.valid;
            mem_resp_q.valid   <= mem_resp_i.valid;
            mem_req_pop_q      <= mem_req_pop_i;
            engine_out_pop_q   <= engine_out_pop_i;
        end
    end

    // --------------------------------------------------
    // Output registers
    // --------------------------------------------------
    // Done also waits for the engine FIFO to hand out its last packet
    always_ff @(posedge ap_clk) begin
        mem_req_o.payload    <= req_dout;
        engine_out_o.payload <= eng_dout;
        if (areset_csr_engine) begin
            mem_req_o.valid      <= 1'b0;
            engine_out_o.valid   <= 1'b0;
            mem_resp_prog_full_o <= 1'b0;
            done_o               <= 1'b1;
        end else begin
            mem_req_o.valid      <= req_dout_valid;
            engine_out_o.valid   <= eng_dout_valid;
            mem_resp_prog_full_o <= resp_status.prog_full;
            done_o               <= gen_done && eng_status.empty && !eng_dout_valid;
        end
    end

    assign req_pop = !req_status.empty && mem_req_pop_q;
    assign eng_pop = !eng_status.empty && engine_out_pop_q;

    // --------------------------------------------------
    // FIFOs
    // --------------------------------------------------
    packet_fifo u_resp_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .push_i(mem_resp_q.valid), .din_i(mem_resp_q.payload), .pop_i(resp_pop),
        .dout_o(resp_dout), .dout_valid_o(resp_dout_valid), .status_o(resp_status)
    );

    packet_fifo u_req_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .push_i(req_push), .din_i(req_din), .pop_i(req_pop),
        .dout_o(req_dout), .dout_valid_o(req_dout_valid), .status_o(req_status)
    );

    packet_fifo u_engine_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .push_i(eng_push), .din_i(eng_din), .pop_i(eng_pop),
        .dout_o(eng_dout), .dout_valid_o(eng_dout_valid), .status_o(eng_status)
    );

    // --------------------------------------------------
    // Routing, configuration and generation
    // --------------------------------------------------
    response_router u_router (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .fifo_dout_i(resp_dout), .fifo_dout_valid_i(resp_dout_valid),
        .fifo_status_i(resp_status), .gen_stall_i(gen_stall),
        .fifo_pop_o(resp_pop), .route_o(route)
    );

    csr_index_configure u_configure (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .cfg_pkt_i(route[0]), .consume_i(cfg_consume), .cfg_o(cfg)
    );

    csr_index_generator u_generator (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .descriptor_i(descriptor_q), .cfg_i(cfg), .resp_i(route[1]),
        .req_fifo_status_i(req_status), .engine_fifo_status_i(eng_status),
        .req_o(req_din), .req_push_o(req_push),
        .engine_o(eng_din), .engine_push_o(eng_push),
        .gen_stall_o(gen_stall), .cfg_consume_o(cfg_consume), .done_o(gen_done)
    );

endmodule

/* test/engine_csr_index_asserts.sv */
`timescale 1ns/1ps

module engine_csr_index_asserts (
    input logic                       ap_clk,
    input logic                       areset_csr_engine,
    input logic                       resp_push_i,
    input csr_index_pkg::fifo_status_t resp_status_i,
    input logic                       req_push_i,
    input csr_index_pkg::fifo_status_t req_status_i,
    input logic                       eng_push_i,
    input csr_index_pkg::fifo_status_t eng_status_i,
    input csr_index_pkg::mem_packet_t mem_req_i,
    input csr_index_pkg::mem_packet_t engine_out_i
);

    int unsigned fail_count = 0;

    // --------------------------------------------------
    // FIFO overflow
    // --------------------------------------------------
    a_resp_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        !(resp_push_i && resp_status_i.full))
        else begin fail_count++; $error("Response FIFO pushed while full"); end

    a_req_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        !(req_push_i && req_status_i.full))
        else begin fail_count++; $error("Request FIFO pushed while full"); end

    a_eng_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        !(eng_push_i && eng_status_i.full))
        else begin fail_count++; $error("Engine FIFO pushed while full"); end

    // Output opcodes
    a_req_opcode: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        mem_req_i.valid |-> mem_req_i.payload.opcode == csr_index_pkg::CMD_READ)
        else begin fail_count++; $error("mem_req_o valid with a non-read opcode"); end

    a_eng_opcode: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        engine_out_i.valid |-> engine_out_i.payload.opcode == csr_index_pkg::CMD_ENGINE_DATA)
        else begin fail_count++; $error("engine_out_o valid with a wrong opcode"); end

endmodule

bind engine_csr_index engine_csr_index_asserts u_asserts (
    .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
    .resp_push_i(mem_resp_q.valid), .resp_status_i(resp_status),
    .req_push_i(req_push), .req_status_i(req_status),
    .eng_push_i(eng_push), .eng_status_i(eng_status),
    .mem_req_i(mem_req_o), .engine_out_i(engine_out_o)
);

/* test/tb_engine_csr_index.sv */
`timescale 1ns/1ps
`include "csr_index_params.svh"

module tb_engine_csr_index;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 8;
    localparam string PATTERN_FILE = "test/csr_index_patterns.txt";

    logic                       ap_clk;
    logic                       areset_csr_engine;
    csr_index_pkg::descriptor_t descriptor_i;
    csr_index_pkg::mem_packet_t mem_resp_i;
    logic                       mem_req_pop_i;
    logic                       engine_out_pop_i;
    logic                       mem_resp_prog_full_o;
    csr_index_pkg::mem_packet_t mem_req_o;
    csr_index_pkg::mem_packet_t engine_out_o;
    logic                       done_o;

    // Pattern table, one entry per file line
    int          test_nums[$];
    int          counts[$];
    logic [31:0] bases[$];
    logic [31:0] starts[$];
    logic [31:0] keys[$];

    csr_index_pkg::mem_payload_t send_q[$];
    csr_index_pkg::mem_payload_t req_seen[$];
    csr_index_pkg::mem_payload_t eng_seen[$];

    logic [31:0] cur_key;
    logic [31:0] rnd;
    logic        random_pops;
    logic        patterns_loaded;
    integer      seed;
    int          check_count;
    int          error_count;
    int          watchdog_cycles;

    engine_csr_index DUT (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .descriptor_i(descriptor_i), .mem_resp_i(mem_resp_i),
        .mem_req_pop_i(mem_req_pop_i), .engine_out_pop_i(engine_out_pop_i),
        .mem_resp_prog_full_o(mem_resp_prog_full_o), .mem_req_o(mem_req_o),
        .engine_out_o(engine_out_o), .done_o(done_o)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic csr_index_pkg::mem_payload_t make_payload(
        input logic id, input csr_index_pkg::csr_opcode_e op,
        input logic [31:0] addr, input logic [31:0] data);
        csr_index_pkg::mem_payload_t p;
        p.id_module = id;
        p.opcode    = op;
        p.address   = addr;
        p.data      = data;
        return p;
    endfunction

    function automatic string payload_text(input csr_index_pkg::mem_payload_t p);
        return $sformatf("id=%0d op=%0d addr=%h data=%h",
                         p.id_module, p.opcode, p.address, p.data);
    endfunction

    task automatic check_packet(input string name, input csr_index_pkg::mem_payload_t exp,
                                input csr_index_pkg::mem_payload_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected %s, actual %s",
                     name, payload_text(exp), payload_text(act));
        end
    endtask

    task automatic check_done(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected done_o=%b, actual done_o=%b", name, exp, act);
        end
    endtask

    task automatic load_patterns();
        int                 fd;
        int                 n;
        int                 t;
        int                 c;
        logic [31:0]        b;
        logic [31:0]        s;
        logic [31:0]        k;
        logic [8*160-1:0]   line_buf;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the pattern file %s", PATTERN_FILE);
            return;
        end
        // Comment lines fail the numeric scan and drop out here
        while (!$feof(fd)) begin
            line_buf = '0;
            n = $fgets(line_buf, fd);
            if (n > 0 && $sscanf(line_buf, "%d %h %h %d %h", t, b, s, c, k) == 5) begin
                test_nums.push_back(t);
                bases.push_back(b);
                starts.push_back(s);
                counts.push_back(c);
                keys.push_back(k);
            end
        end
        $fclose(fd);
        if (test_nums.size() == 0) begin
            error_count++;
            $display("The pattern file holds no test lines");
        end
    endtask

    // --------------------------------------------------
    // Memory side and pop levels
    // --------------------------------------------------
    always @(posedge ap_clk) begin
        #1;
        if (!areset_csr_engine && send_q.size() > 0 && !mem_resp_prog_full_o) begin
            mem_resp_i.payload = send_q.pop_front();
            mem_resp_i.valid   = 1'b1;
        end else begin
            mem_resp_i.valid = 1'b0;
        end
        if (random_pops) begin
            rnd              = $random(seed);
            mem_req_pop_i    = rnd[0];
            engine_out_pop_i = rnd[1];
        end else begin
            mem_req_pop_i    = 1'b1;
            engine_out_pop_i = 1'b1;
        end
    end

    // Requests are answered in order, engine packets collected
    always @(negedge ap_clk) begin
        if (mem_req_o.valid) begin
            req_seen.push_back(mem_req_o.payload);
            send_q.push_back(make_payload(1'b1, csr_index_pkg::CMD_READ_RESP,
                             mem_req_o.payload.address, mem_req_o.payload.address ^ cur_key));
        end
        if (engine_out_o.valid) begin
            eng_seen.push_back(engine_out_o.payload);
            if (done_o) begin
                error_count++;
                $display("An engine packet was delivered while done_o was high");
            end
        end
    end

    // --------------------------------------------------
    // One pattern line
    // --------------------------------------------------
    task automatic run_test(input int idx);
        string                       name;
        int                          cnt;
        int                          k;
        int                          waited;
        logic [31:0]                 addr;
        csr_index_pkg::mem_payload_t exp_pkt;
        name        = $sformatf("test %0d", test_nums[idx]);
        cnt         = counts[idx];
        cur_key     = keys[idx];
        random_pops = (test_nums[idx] == 3);
        req_seen.delete();
        eng_seen.delete();
        send_q.push_back(make_payload(1'b0, csr_index_pkg::CMD_CONFIG,
                         {30'd0, csr_index_pkg::FIELD_BASE}, bases[idx]));
        send_q.push_back(make_payload(1'b0, csr_index_pkg::CMD_CONFIG,
                         {30'd0, csr_index_pkg::FIELD_START}, starts[idx]));
        send_q.push_back(make_payload(1'b0, csr_index_pkg::CMD_CONFIG,
                         {30'd0, csr_index_pkg::FIELD_COUNT}, 32'(cnt)));
        while (send_q.size() != 0) @(negedge ap_clk);
        @(posedge ap_clk);
        #1;
        descriptor_i.kernel_tag = 32'(test_nums[idx]);
        descriptor_i.valid      = 1'b1;
        @(posedge ap_clk);
        #1;
        descriptor_i.valid = 1'b0;
        // Zero count runs drop done_o for only a couple of cycles
        waited = 0;
        @(negedge ap_clk);
        while (done_o && waited < 32) begin
            @(negedge ap_clk);
            waited++;
        end
        check_done({name, " after descriptor"}, 1'b0, done_o);
        while (!done_o) @(negedge ap_clk);
        // Quiet window catches late or duplicated packets
        repeat (10) @(negedge ap_clk);
        random_pops = 1'b0;
        // All responses have been routed, so the response FIFO is empty again
        check_count++;
        if (mem_resp_prog_full_o !== 1'b0) begin
            error_count++;
            $display("[FAIL] %s response prog_full after drain: expected 0, actual %b",
                     name, mem_resp_prog_full_o);
        end
        check_count += 2;
        if (req_seen.size() != cnt) begin
            error_count++;
            $display("[FAIL] %s request count: expected %0d, actual %0d",
                     name, cnt, req_seen.size());
        end
        if (eng_seen.size() != cnt) begin
            error_count++;
            $display("[FAIL] %s engine packet count: expected %0d, actual %0d",
                     name, cnt, eng_seen.size());
        end
        for (k = 0; k < cnt; k++) begin
            addr = bases[idx] + (starts[idx] + k) * `CSR_WORD_BYTES;
            if (k < req_seen.size()) begin
                exp_pkt = make_payload(1'b1, csr_index_pkg::CMD_READ, addr, 32'd0);
                check_packet($sformatf("%s request %0d", name, k), exp_pkt, req_seen[k]);
            end
            if (k < eng_seen.size()) begin
                exp_pkt = make_payload(1'b1, csr_index_pkg::CMD_ENGINE_DATA, addr,
                                       addr ^ keys[idx]);
                check_packet($sformatf("%s engine packet %0d", name, k), exp_pkt, eng_seen[k]);
            end
        end
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        int idx;
        int total;
        ap_clk            = 1'b0;
        areset_csr_engine = 1'b1;
        descriptor_i      = '0;
        mem_resp_i        = '0;
        mem_req_pop_i     = 1'b1;
        engine_out_pop_i  = 1'b1;
        random_pops       = 1'b0;
        patterns_loaded   = 1'b0;
        cur_key           = '0;
        seed              = 42;
        check_count       = 0;
        error_count       = 0;
        load_patterns();
        total = 0;
        for (idx = 0; idx < counts.size(); idx++) begin
            total += counts[idx];
        end
        watchdog_cycles = total * 40 + 500;
        patterns_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        #1;
        areset_csr_engine = 1'b0;
        @(negedge ap_clk);
        check_done("reset", 1'b1, done_o);
        check_count++;
        if (mem_req_o.valid !== 1'b0 || engine_out_o.valid !== 1'b0) begin
            error_count++;
            $display("[FAIL] reset valids: expected 0 0, actual %b %b",
                     mem_req_o.valid, engine_out_o.valid);
        end
        check_count++;
        if (mem_resp_prog_full_o !== 1'b0) begin
            error_count++;
            $display("[FAIL] reset prog_full: expected 0, actual %b", mem_resp_prog_full_o);
        end
        for (idx = 0; idx < test_nums.size(); idx++) begin
            run_test(idx);
        end
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, DUT.u_asserts.fail_count);
        if (error_count == 0 && DUT.u_asserts.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (patterns_loaded);
        repeat (watchdog_cycles) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles before all tests finished", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* test/csr_index_patterns.txt */
# test  base      start     count  key
# test and count in decimal, base, start and key in hex
1  00001000  00000000  8   a5a5a5a5
2  00020000  00000010  24  0f0f0f0f
3  00100000  00000040  60  deadbeef
4  00003000  00000005  0   12345678
5  fffffff0  00000002  6   ffffffff
6  00040000  00001000  1   00000000
7  00008000  00000020  33  5a5a0000

/* build.f */
+incdir+hw
hw/csr_index_pkg.sv
hw/packet_fifo.sv
hw/response_router.sv
hw/csr_index_configure.sv
hw/csr_index_generator.sv
hw/engine_csr_index.sv
test/engine_csr_index_asserts.sv
test/tb_engine_csr_index.sv
